// File: src/serv_pkg.sv
`default_nettype none

package serv_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Word and index types.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  cnt_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Encodings.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   // One instruction at a time walks through these phases.
   typedef enum logic [1:0] {
      ST_FETCH,
      ST_LOAD,
      ST_EXEC,
      ST_RETIRE
   } ctrl_state_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bundles.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef struct packed {
      alu_op_e   alu_op;
      logic      op_b_imm;
      logic      rd_we;
      reg_addr_t rd_addr;
      reg_addr_t rs1_addr;
      reg_addr_t rs2_addr;
      word_t     insn;
   } dec_ctrl_t;

   typedef struct packed {
      logic      valid;
      word_t     pc;
      word_t     insn;
      logic      rd_we;
      reg_addr_t rd_addr;
      word_t     rd_wdata;
   } retire_t;

endpackage

`default_nettype wire

// File: src/serv_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module serv_ctrl #(
   parameter serv_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  wire                   clk,
   input  wire                   i_rst_n,
   input  wire                   i_ibus_ack,
   output serv_pkg::word_t       o_ibus_adr,
   output logic                  o_ibus_cyc,
   output serv_pkg::ctrl_state_e o_state,
   output serv_pkg::cnt_t        o_cnt
);
   import serv_pkg::*;

   ctrl_state_e state;
   cnt_t        cnt;
   word_t       pc;

   // Phase sequencer and program counter.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_FETCH;
         cnt   <= '0;
         pc    <= RESET_PC;
      end else begin
         case (state)
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= ST_LOAD;
               end
            end
            ST_LOAD: begin
               cnt   <= '0;
               state <= ST_EXEC;
            end
            ST_EXEC: begin
               // Wraps back to zero after bit 31.
               cnt <= cnt + cnt_t'(1);
               if (cnt == '1) begin
                  state <= ST_RETIRE;
               end
            end
            default: begin
               pc    <= pc + 32'd4;
               state <= ST_FETCH;
            end
         endcase
      end
   end

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_ibus_adr = pc;
   assign o_state    = state;
   assign o_cnt      = cnt;

endmodule

`default_nettype wire

// File: src/serv_decode.sv
`default_nettype none
`timescale 1ns/100ps

module serv_decode (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  wire serv_pkg::ctrl_state_e i_state,
   input  wire serv_pkg::word_t       i_ibus_rdt,
   input  wire                        i_ibus_ack,
   output serv_pkg::dec_ctrl_t        o_ctrl,
   output logic                       o_imm
);
   import serv_pkg::*;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] F7_SUB     = 7'b0100000;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       supported;
   dec_ctrl_t  dec_next;
   word_t      imm_next;
   word_t      imm_q;

   assign opcode = i_ibus_rdt[6:0];
   assign funct3 = i_ibus_rdt[14:12];
   assign funct7 = i_ibus_rdt[31:25];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Instruction decode.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      supported         = 1'b1;
      dec_next          = '0;
      dec_next.alu_op   = ALU_ADD;
      dec_next.op_b_imm = (opcode != OPC_OP);
      dec_next.rd_addr  = i_ibus_rdt[11:7];
      dec_next.rs1_addr = (opcode == OPC_LUI) ? '0 : i_ibus_rdt[19:15];
      dec_next.rs2_addr = i_ibus_rdt[24:20];
      dec_next.insn     = i_ibus_rdt;

      case (funct3)
         3'b000: dec_next.alu_op = ((opcode == OPC_OP) && (funct7 == F7_SUB)) ? ALU_SUB : ALU_ADD;
         3'b010: dec_next.alu_op = ALU_SLT;
         3'b011: dec_next.alu_op = ALU_SLTU;
         3'b100: dec_next.alu_op = ALU_XOR;
         3'b110: dec_next.alu_op = ALU_OR;
         3'b111: dec_next.alu_op = ALU_AND;
         // Shifts are not implemented.
         default: supported = 1'b0;
      endcase

      case (opcode)
         OPC_OP: begin
            if ((funct7 != '0) && !((funct7 == F7_SUB) && (funct3 == 3'b000))) begin
               supported = 1'b0;
            end
         end
         OPC_OP_IMM: begin
         end
         OPC_LUI: begin
            // Upper immediate added to x0.
            dec_next.alu_op = ALU_ADD;
            supported       = 1'b1;
         end
         default: supported = 1'b0;
      endcase

      dec_next.rd_we = supported && (dec_next.rd_addr != '0);
   end

   assign imm_next = (opcode == OPC_LUI) ? {i_ibus_rdt[31:12], 12'b0}
                                          : {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ctrl <= '0;
      end else if (i_ibus_ack) begin
         o_ctrl <= dec_next;
      end
   end

   // Immediate is fed to the ALU LSB first.
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= imm_next;
      end else if (i_state == ST_EXEC) begin
         imm_q <= {1'b0, imm_q[31:1]};
      end
   end

   assign o_imm = imm_q[0];

endmodule

`default_nettype wire

// File: src/serv_regfile.sv
`default_nettype none
`timescale 1ns/100ps

module serv_regfile (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  wire serv_pkg::ctrl_state_e i_state,
   input  wire serv_pkg::dec_ctrl_t   i_ctrl,
   input  wire serv_pkg::word_t       i_result,
   output logic                       o_rs1,
   output logic                       o_rs2,
   output serv_pkg::word_t            o_rs1_word
);
   import serv_pkg::*;

   word_t regs [1:31];
   word_t rs1_rdata;
   word_t rs2_rdata;
   word_t rs1_q;
   word_t rs2_q;

   // x0 is hardwired to zero.
   assign rs1_rdata = (i_ctrl.rs1_addr == '0) ? '0 : regs[i_ctrl.rs1_addr];
   assign rs2_rdata = (i_ctrl.rs2_addr == '0) ? '0 : regs[i_ctrl.rs2_addr];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if ((i_state == ST_RETIRE) && i_ctrl.rd_we) begin
         regs[i_ctrl.rd_addr] <= i_result;
      end
   end

   // Operands rotate, so the full word is back in place after 32 bits.
   always_ff @(posedge clk) begin
      if (i_state == ST_LOAD) begin
         rs1_q <= rs1_rdata;
         rs2_q <= rs2_rdata;
      end else if (i_state == ST_EXEC) begin
         rs1_q <= {rs1_q[0], rs1_q[31:1]};
         rs2_q <= {rs2_q[0], rs2_q[31:1]};
      end
   end

   assign o_rs1      = rs1_q[0];
   assign o_rs2      = rs2_q[0];
   assign o_rs1_word = rs1_q;

endmodule

`default_nettype wire

// File: src/serv_alu.sv
`default_nettype none
`timescale 1ns/100ps

module serv_alu (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  wire serv_pkg::ctrl_state_e i_state,
   input  wire serv_pkg::cnt_t        i_cnt,
   input  wire serv_pkg::dec_ctrl_t   i_ctrl,
   input  wire                        i_rs1,
   input  wire                        i_rs2,
   input  wire                        i_imm,
   output serv_pkg::word_t            o_result
);
   import serv_pkg::*;

   logic  exec;
   logic  op_b;
   logic  sub;
   logic  b_in;
   logic  c_in;
   logic  sum;
   logic  c_out;
   logic  res_bit;
   logic  carry_q;
   logic  sign_a;
   logic  sign_b;
   logic  lt_s;
   logic  lt_u;
   word_t res_q;

   assign exec = (i_state == ST_EXEC);
   assign op_b = i_ctrl.op_b_imm ? i_imm : i_rs2;
   assign sub  = (i_ctrl.alu_op == ALU_SUB) || (i_ctrl.alu_op == ALU_SLT) ||
                 (i_ctrl.alu_op == ALU_SLTU);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Serial adder, one bit per cycle.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign b_in  = op_b ^ sub;
   assign c_in  = (i_cnt == '0) ? sub : carry_q;
   assign sum   = i_rs1 ^ b_in ^ c_in;
   assign c_out = (i_rs1 & b_in) | (c_in & (i_rs1 ^ b_in));

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND: res_bit = i_rs1 & op_b;
         ALU_OR:  res_bit = i_rs1 | op_b;
         ALU_XOR: res_bit = i_rs1 ^ op_b;
         default: res_bit = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (exec) begin
         carry_q <= c_out;
      end
   end

   always_ff @(posedge clk) begin
      if (exec) begin
         res_q <= {res_bit, res_q[31:1]};
         if (i_cnt == '1) begin
            sign_a <= i_rs1;
            sign_b <= op_b;
         end
      end
   end

   // Less-than from the sign bits and the final carry of a - b.
   assign lt_s = (sign_a ^ sign_b) ? sign_a : res_q[31];
   assign lt_u = ~carry_q;

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_SLT:  o_result = {31'b0, lt_s};
         ALU_SLTU: o_result = {31'b0, lt_u};
         default:  o_result = res_q;
      endcase
   end

endmodule

`default_nettype wire

// File: src/serv_top.sv
`default_nettype none
`timescale 1ns/100ps

module serv_top #(
   parameter serv_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  wire                  clk,
   input  wire                  i_rst_n,
   output serv_pkg::word_t      o_ibus_adr,
   output logic                 o_ibus_cyc,
   input  wire serv_pkg::word_t i_ibus_rdt,
   input  wire                  i_ibus_ack,
   output serv_pkg::retire_t    o_retire
);
   import serv_pkg::*;

   ctrl_state_e state;
   cnt_t        cnt;
   dec_ctrl_t   dec_ctrl;
   logic        imm;
   logic        rs1;
   logic        rs2;
   word_t       result;

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_state    (state),
      .o_cnt      (cnt)
   );

   serv_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_state    (state),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_ctrl     (dec_ctrl),
      .o_imm      (imm)
   );

   serv_regfile u_regfile (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_state    (state),
      .i_ctrl     (dec_ctrl),
      .i_result   (result),
      .o_rs1      (rs1),
      .o_rs2      (rs2),
      .o_rs1_word ()
   );

   serv_alu u_alu (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_state  (state),
      .i_cnt    (cnt),
      .i_ctrl   (dec_ctrl),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .o_result (result)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Retirement record.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      o_retire.valid   = (state == ST_RETIRE);
      o_retire.pc      = o_ibus_adr;
      o_retire.insn    = dec_ctrl.insn;
      o_retire.rd_we   = dec_ctrl.rd_we;
      o_retire.rd_addr = dec_ctrl.rd_addr;
      // Write data reads as zero when nothing is written.
      o_retire.rd_wdata = dec_ctrl.rd_we ? result : '0;
   end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
   parameter int HALF_PERIOD_NS = 20,
   parameter int RESET_CYCLES   = 3
) (
   output logic clk,
   output logic o_rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   // Reset is released on a rising edge.
   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      o_rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/serv_sva.sv
`default_nettype none
`timescale 1ns/100ps

module serv_sva (
   input wire                    clk,
   input wire                    i_rst_n,
   input wire                    i_ibus_cyc,
   input wire serv_pkg::word_t   i_ibus_adr,
   input wire                    i_ibus_ack,
   input wire serv_pkg::retire_t i_retire
);

   int unsigned fail_count = 0;

   // Request held with a steady address until the ack.
   a_cyc_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc && $stable(i_ibus_adr))
      else begin
         fail_count++;
         $error("fetch request dropped or address changed before ack");
      end

   a_ack_in_cyc: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_ack |-> i_ibus_cyc)
      else begin
         fail_count++;
         $error("ack without a fetch request");
      end

   a_cyc_low_after_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && i_ibus_ack |=> !i_ibus_cyc)
      else begin
         fail_count++;
         $error("fetch request still high after ack");
      end

   // A new request only follows a retirement.
   a_cyc_after_retire: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(i_ibus_cyc) |-> $past(i_retire.valid))
      else begin
         fail_count++;
         $error("fetch request raised without a retirement");
      end

   a_retire_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_retire.valid |-> $past(i_ibus_cyc && i_ibus_ack, 34))
      else begin
         fail_count++;
         $error("retirement not 34 cycles after ack");
      end

   a_retire_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_retire.valid |=> !i_retire.valid)
      else begin
         fail_count++;
         $error("retire valid longer than one cycle");
      end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`default_nettype none
`timescale 1ns/100ps

module tb_top;
   import serv_pkg::*;

   localparam word_t      RESET_PC     = 32'h0000_1000;
   localparam int         NUM_RETIRE   = 300;
   localparam int         WAIT_LIMIT   = 64;
   localparam int         EXEC_LATENCY = 34;
   localparam logic [6:0] OPC_OP       = 7'b0110011;
   localparam logic [6:0] OPC_IMM      = 7'b0010011;
   localparam logic [6:0] OPC_LUI      = 7'b0110111;

   logic    clk;
   logic    rst_n;
   word_t   ibus_adr;
   logic    ibus_cyc;
   word_t   ibus_rdt;
   logic    ibus_ack;
   retire_t retire;

   integer  seed = 32'hfe08_7b30;
   word_t   model_regs [0:31];
   word_t   model_pc;

   tb_clk_gen u_clk_gen (
      .clk     (clk),
      .o_rst_n (rst_n)
   );

   serv_top #(
      .RESET_PC (RESET_PC)
   ) u_dut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_retire   (retire)
   );

   bind serv_top serv_sva u_sva (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_adr (o_ibus_adr),
      .i_ibus_ack (i_ibus_ack),
      .i_retire   (o_retire)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Failure handling and compares.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "Simulation stopped at the first failure.");
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_reg_addr(input string what, input reg_addr_t got,
                                 input reg_addr_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus and reference model.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic word_t random_instruction();
      word_t      r;
      word_t      insn;
      int         kind;
      reg_addr_t  rd;
      reg_addr_t  rs1;
      reg_addr_t  rs2;
      logic [2:0] f3;
      r    = $random(seed);
      kind = {$random(seed)} % 20;
      rd   = {2'b00, r[9:7]};
      rs1  = {2'b00, r[17:15]};
      rs2  = {2'b00, r[22:20]};
      // ADD, SLT, SLTU, XOR, OR and AND in turn.
      case (kind % 6)
         0: f3 = 3'b000;
         1: f3 = 3'b010;
         2: f3 = 3'b011;
         3: f3 = 3'b100;
         4: f3 = 3'b110;
         default: f3 = 3'b111;
      endcase
      if (kind < 6) begin
         insn = {7'b0000000, rs2, rs1, f3, rd, OPC_OP};
      end else if (kind == 6) begin
         insn = {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
      end else if (kind < 15) begin
         insn = {r[31:20], rs1, f3, rd, OPC_IMM};
      end else if (kind < 18) begin
         insn = {r[31:12], rd, OPC_LUI};
      end else begin
         // Load, branch, MUL and SLLI are outside the set.
         case (r[1:0])
            2'd0: insn = {r[31:20], rs1, 3'b010, rd, 7'b0000011};
            2'd1: insn = {r[31:7], 7'b1100011};
            2'd2: insn = {7'b0000001, rs2, rs1, r[14:12], rd, OPC_OP};
            default: insn = {7'b0000000, r[24:20], rs1, 3'b001, rd, OPC_IMM};
         endcase
      end
      return insn;
   endfunction

   task automatic model_retire(input word_t insn, output retire_t exp);
      logic [6:0] opc;
      logic [6:0] f7;
      logic [2:0] f3;
      word_t      a;
      word_t      b;
      word_t      res;
      logic       wr;
      opc = insn[6:0];
      f3  = insn[14:12];
      f7  = insn[31:25];
      a   = model_regs[insn[19:15]];
      b   = (opc == OPC_OP) ? model_regs[insn[24:20]] : {{20{insn[31]}}, insn[31:20]};
      res = '0;
      wr  = (opc == OPC_IMM) ||
            ((opc == OPC_OP) && ((f7 == 7'b0) || ((f7 == 7'b0100000) && (f3 == 3'b000))));
      case (f3)
         3'b000: res = ((opc == OPC_OP) && f7[5]) ? a - b : a + b;
         3'b010: res = word_t'($signed(a) < $signed(b));
         3'b011: res = word_t'(a < b);
         3'b100: res = a ^ b;
         3'b110: res = a | b;
         3'b111: res = a & b;
         default: wr = 1'b0;
      endcase
      if (opc == OPC_LUI) begin
         wr  = 1'b1;
         res = {insn[31:12], 12'b0};
      end
      if (insn[11:7] == 5'd0) begin
         wr = 1'b0;
      end
      exp.valid    = 1'b1;
      exp.pc       = model_pc;
      exp.insn     = insn;
      exp.rd_we    = wr;
      exp.rd_addr  = insn[11:7];
      exp.rd_wdata = wr ? res : '0;
      if (wr) begin
         model_regs[insn[11:7]] = res;
      end
      model_pc = model_pc + 32'd4;
   endtask

   task automatic wait_for_reset();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1) begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            $display("Timeout at %0t ns: reset was never released", $time);
            abort_run();
         end
      end
   endtask

   task automatic wait_for_fetch();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         check_flag("retire valid while no instruction is in flight", retire.valid, 1'b0);
         if (cycles > WAIT_LIMIT) begin
            $display("Timeout at %0t ns: the DUT never requested an instruction", $time);
            abort_run();
         end
      end while (ibus_cyc !== 1'b1);
   endtask

   task automatic run_one_instruction();
      word_t   insn;
      retire_t exp;
      int      delay;
      int      cycles;
      wait_for_fetch();
      check_word("fetch address", ibus_adr, model_pc);
      insn  = random_instruction();
      delay = {$random(seed)} % 4;
      repeat (delay) begin
         @(posedge clk);
         check_flag("ibus_cyc before ack", ibus_cyc, 1'b1);
         check_word("fetch address before ack", ibus_adr, model_pc);
      end
      ibus_ack <= 1'b1;
      ibus_rdt <= insn;
      @(posedge clk);
      check_flag("ibus_cyc in the ack cycle", ibus_cyc, 1'b1);
      ibus_ack <= 1'b0;
      ibus_rdt <= $random(seed);
      model_retire(insn, exp);
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         check_flag("ibus_cyc between ack and retire", ibus_cyc, 1'b0);
         if (cycles > WAIT_LIMIT) begin
            $display("Timeout at %0t ns: instruction %h never retired", $time, insn);
            abort_run();
         end
      end while (retire.valid !== 1'b1);
      check_word("cycles from ack to retire", word_t'(cycles), word_t'(EXEC_LATENCY));
      check_word("retire pc", retire.pc, exp.pc);
      check_word("retire insn", retire.insn, exp.insn);
      check_flag("retire rd_we", retire.rd_we, exp.rd_we);
      if (exp.rd_we) begin
         check_reg_addr("retire rd_addr", retire.rd_addr, exp.rd_addr);
         check_word("retire rd_wdata", retire.rd_wdata, exp.rd_wdata);
      end
   endtask

   initial begin
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      model_pc = RESET_PC;
      wait_for_reset();
      for (int n = 0; n < NUM_RETIRE; n++) begin
         run_one_instruction();
      end
      if (u_dut.u_sva.fail_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
src/serv_pkg.sv
src/serv_ctrl.sv
src/serv_decode.sv
src/serv_regfile.sv
src/serv_alu.sv
src/serv_top.sv
testbench/tb_clk_gen.sv
testbench/serv_sva.sv
testbench/tb_top.sv

// File: Makefile
SIM_LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
	./obj_dir/tb_sim | tee $(SIM_LOG)
	@grep -qx "No errors" $(SIM_LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(SIM_LOG)
